// ==== dv/edge_read_stim.txt ====
# command unit offset half0 half1 argument, all fields hex
# R sends a pair (argument is the expected word), I idles, E sets enable, H holds out_ready, D ends a test
I 0 0 0000000000000000 0000000000000000 00000014
D 0 0 0000000000000000 0000000000000000 0000000c
R 1 0 0123456789abcdef fedcba9876543210 67452301
R 1 1 0123456789abcdef fedcba9876543210 efcdab89
R 1 2 0123456789abcdef fedcba9876543210 98badcfe
R 1 3 0123456789abcdef fedcba9876543210 10325476
D 0 0 0000000000000000 0000000000000000 0000000c
R 0 0 3100a0a13100b0b1 3100c0c13100d0d1 a1a00031
R 3 1 3200a0a13200b0b1 3200c0c13200d0d1 b1b00032
R 2 2 3300a0a13300b0b1 3300c0c13300d0d1 c1c00033
R 0 3 3400a0a13400b0b1 3400c0c13400d0d1 d1d00034
R 1 0 3500a0a13500b0b1 3500c0c13500d0d1 a1a00035
R 3 2 3600a0a13600b0b1 3600c0c13600d0d1 c1c00036
D 0 0 0000000000000000 0000000000000000 0000000c
E 0 0 0000000000000000 0000000000000000 00000000
R 1 0 4100a0a14100b0b1 4100c0c14100d0d1 a1a00041
R 2 3 4200a0a14200b0b1 4200c0c14200d0d1 d1d00042
E 0 0 0000000000000000 0000000000000000 00000001
R 1 1 4300a0a14300b0b1 4300c0c14300d0d1 b1b00043
R 2 2 4400a0a14400b0b1 4400c0c14400d0d1 c1c00044
D 0 0 0000000000000000 0000000000000000 0000000c
H 0 0 0000000000000000 0000000000000000 00000040
R 2 0 5100a0a15100b0b1 5100c0c15100d0d1 a1a00051
R 2 1 5200a0a15200b0b1 5200c0c15200d0d1 b1b00052
R 0 2 5300a0a15300b0b1 5300c0c15300d0d1 c1c00053
R 2 3 5400a0a15400b0b1 5400c0c15400d0d1 d1d00054
R 2 0 5500a0a15500b0b1 5500c0c15500d0d1 a1a00055
R 2 1 5600a0a15600b0b1 5600c0c15600d0d1 b1b00056
R 2 2 5700a0a15700b0b1 5700c0c15700d0d1 c1c00057
R 0 3 5800a0a15800b0b1 5800c0c15800d0d1 d1d00058
R 2 3 5900a0a15900b0b1 5900c0c15900d0d1 d1d00059
R 2 0 5a00a0a15a00b0b1 5a00c0c15a00d0d1 a1a0005a
D 0 0 0000000000000000 0000000000000000 0000000c

// ==== filelist.f ====
+incdir+logic
logic/graph_pkg.sv
logic/sync_fifo.sv
logic/read_response_router.sv
logic/edge_data_read_control.sv
logic/edge_data_collector.sv
logic/edge_read_top.sv
dv/edge_read_tb.sv

// ==== Bender.yml ====
package:
  name: edge_read

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/graph_pkg.sv
      - logic/sync_fifo.sv
      - logic/read_response_router.sv
      - logic/edge_data_read_control.sv
      - logic/edge_data_collector.sv
      - logic/edge_read_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/edge_read_tb.sv

// ==== dv/edge_read_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Edge read path testbench
// Replays response pairs from the stimulus file and checks each
// delivered edge word against per-unit expected queues
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "graph_defines.svh"

module edge_read_tb import graph_pkg::*; ();

	localparam int EXP_DEPTH   = 64;
	localparam int DRAIN_LIMIT = 400;

	logic         clock;
	logic         rstn;
	logic         enable;
	logic         resp0_valid;
	cu_id_t       resp0_cu;
	word_offset_t resp0_offset;
	half_line_t   resp0_data;
	logic         resp1_valid;
	cu_id_t       resp1_cu;
	word_offset_t resp1_offset;
	half_line_t   resp1_data;
	logic         out_ready;
	logic         edge_valid;
	cu_id_t       edge_cu;
	edge_word_t   edge_data;

	// Expected words per unit, oldest at the head
	edge_word_t   exp_mem [`NUM_CU][EXP_DEPTH];
	int           exp_head [`NUM_CU];
	int           exp_tail [`NUM_CU];

	integer       seed;
	int           hold_left;
	logic         enable_level;
	int           cur_test;
	int           sent_count;
	int           recv_count;
	int           test_errors;
	int           errors;
	int           checks;
	bit           timed_out;

	edge_read_top dut0 (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.resp0_valid (resp0_valid),
		.resp0_cu    (resp0_cu),
		.resp0_offset(resp0_offset),
		.resp0_data  (resp0_data),
		.resp1_valid (resp1_valid),
		.resp1_cu    (resp1_cu),
		.resp1_offset(resp1_offset),
		.resp1_data  (resp1_data),
		.out_ready   (out_ready),
		.edge_valid  (edge_valid),
		.edge_cu     (edge_cu),
		.edge_data   (edge_data)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic string test_name(input int id);
		case (id)
			1:       return "reset_idle";
			2:       return "word_select";
			3:       return "unit_interleave";
			4:       return "enable_gate";
			5:       return "back_pressure";
			default: return "extra";
		endcase
	endfunction

	function automatic int outstanding();
		int total;
		total = 0;
		for (int i = 0; i < `NUM_CU; i++) begin
			total += exp_tail[i] - exp_head[i];
		end
		return total;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	// One clock, out_ready follows the hold counter
	task automatic step_cycle();
		@(posedge clock);
		out_ready <= (hold_left == 0);
		if (hold_left > 0) begin
			hold_left--;
		end
	endtask

	task automatic idle_cycle();
		step_cycle();
		resp0_valid <= 1'b0;
		resp1_valid <= 1'b0;
	endtask

	// Half 1 first, half 0 one cycle later
	task automatic send_pair(input cu_id_t cu, input word_offset_t off, input half_line_t h0,
			input half_line_t h1, input edge_word_t expected);
		step_cycle();
		resp0_valid  <= 1'b0;
		resp1_valid  <= 1'b1;
		resp1_cu     <= cu;
		resp1_offset <= off;
		resp1_data   <= h1;
		step_cycle();
		resp1_valid  <= 1'b0;
		resp0_valid  <= 1'b1;
		resp0_cu     <= cu;
		resp0_offset <= off;
		resp0_data   <= h0;
		if (enable_level) begin
			exp_mem[cu][exp_tail[cu] % EXP_DEPTH] = expected;
			exp_tail[cu]++;
			sent_count++;
		end
	endtask

	task automatic take_word(input cu_id_t cu, input edge_word_t data);
		recv_count++;
		if (exp_tail[cu] == exp_head[cu]) begin
			$display("unexpected word %h from unit %0d in test %s", data, cu,
				test_name(cur_test));
			errors++;
			test_errors++;
		end else begin
			check_value(test_name(cur_test), exp_mem[cu][exp_head[cu] % EXP_DEPTH], data);
			exp_head[cu]++;
		end
	endtask

	task automatic drain_words();
		int waited;
		waited = 0;
		while (outstanding() != 0 && waited < DRAIN_LIMIT) begin
			idle_cycle();
			waited++;
		end
		if (outstanding() != 0) begin
			$display("timeout: %0d words of test %s never came out", outstanding(),
				test_name(cur_test));
			timed_out = 1'b1;
		end
	endtask

	task automatic close_test(input int settle);
		drain_words();
		repeat (settle) idle_cycle();
		check_value({test_name(cur_test), " word count"}, 64'(sent_count), 64'(recv_count));
		$display("test %0d %s: %0d of %0d words, %0d errors", cur_test, test_name(cur_test),
			recv_count, sent_count, test_errors);
		cur_test++;
		sent_count  = 0;
		recv_count  = 0;
		test_errors = 0;
	endtask

	task automatic run_command(input int cmd, input logic [31:0] cu, input logic [31:0] off,
			input half_line_t h0, input half_line_t h1, input logic [31:0] arg);
		case (cmd)
			"R": send_pair(cu_id_t'(cu), word_offset_t'(off), h0, h1, edge_word_t'(arg));
			"I": repeat (arg) idle_cycle();
			"E": begin
				drain_words();
				idle_cycle();
				enable       <= arg[0];
				enable_level = arg[0];
			end
			"H": hold_left = 16 + int'($unsigned($random(seed)) % arg);
			"D": close_test(int'(arg));
			default: begin
				$display("unknown command %c in the stimulus file", cmd);
				errors++;
			end
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Output monitor
	//////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (rstn && edge_valid) begin
			take_word(edge_cu, edge_data);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int          fd;
		int          c;
		int          n;
		logic [31:0] f_cu;
		logic [31:0] f_off;
		half_line_t  f_h0;
		half_line_t  f_h1;
		logic [31:0] f_arg;
		bit          file_done;

		seed         = 32'h3fb1_83e4;
		rstn         = 1'b0;
		enable       = 1'b1;
		enable_level = 1'b1;
		out_ready    = 1'b1;
		resp0_valid  = 1'b0;
		resp0_cu     = '0;
		resp0_offset = '0;
		resp0_data   = '0;
		resp1_valid  = 1'b0;
		resp1_cu     = '0;
		resp1_offset = '0;
		resp1_data   = '0;
		hold_left    = 0;
		cur_test     = 1;
		sent_count   = 0;
		recv_count   = 0;
		test_errors  = 0;
		errors       = 0;
		checks       = 0;
		timed_out    = 1'b0;
		file_done    = 1'b0;
		for (int i = 0; i < `NUM_CU; i++) begin
			exp_head[i] = 0;
			exp_tail[i] = 0;
		end

		repeat (10) @(posedge clock);
		rstn <= 1'b1;

		fd = $fopen("dv/edge_read_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file dv/edge_read_stim.txt");
			errors++;
			file_done = 1'b1;
		end

		// One command letter per line, then five hex fields
		while (!file_done && !timed_out) begin
			c = $fgetc(fd);
			if (c == -1) begin
				file_done = 1'b1;
			end else if (c == "#") begin
				while (c != "\n" && c != -1) begin
					c = $fgetc(fd);
				end
			end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
				n = $fscanf(fd, " %h %h %h %h %h", f_cu, f_off, f_h0, f_h1, f_arg);
				if (n != 5) begin
					$display("malformed line for command %c in the stimulus file", c);
					errors++;
					file_done = 1'b1;
				end else begin
					run_command(c, f_cu, f_off, f_h0, f_h1, f_arg);
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		if (!timed_out && outstanding() != 0) begin
			$display("%0d expected words were never delivered", outstanding());
			errors++;
		end

		$display("%0d tests, %0d checks, %0d errors", cur_test - 1, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== logic/edge_read_top.sv ====
//////////////////////////////////////////////////////////////////////
// Edge read top
// Router, per-unit read control blocks and output collector
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "graph_defines.svh"

module edge_read_top import graph_pkg::*; (
	input  logic         clock,
	input  logic         rstn,
	input  logic         enable,
	input  logic         resp0_valid,
	input  cu_id_t       resp0_cu,
	input  word_offset_t resp0_offset,
	input  half_line_t   resp0_data,
	input  logic         resp1_valid,
	input  cu_id_t       resp1_cu,
	input  word_offset_t resp1_offset,
	input  half_line_t   resp1_data,
	input  logic         out_ready,
	output logic         edge_valid,
	output cu_id_t       edge_cu,
	output edge_word_t   edge_data
);

	logic [`NUM_CU-1:0] half0_valid;
	logic [`NUM_CU-1:0] half1_valid;
	half_line_t         half0_data;
	half_line_t         half1_data;
	word_offset_t       offset;
	logic [`NUM_CU-1:0] edge_request;
	logic [`NUM_CU-1:0] word_valid;
	edge_word_t         word [`NUM_CU];

	// Half 1 offset duplicates half 0, kept for the pair check only
	a_offset_match: assert property (
		@(posedge clock) disable iff (!rstn)
		(enable && resp0_valid) |-> (resp0_offset == $past(resp1_offset))
	) else $error("half 0 offset differs from its half 1");

	read_response_router router (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.resp0_valid (resp0_valid),
		.resp1_valid (resp1_valid),
		.resp0_cu    (resp0_cu),
		.resp1_cu    (resp1_cu),
		.resp0_offset(resp0_offset),
		.resp0_data  (resp0_data),
		.resp1_data  (resp1_data),
		.half0_valid (half0_valid),
		.half1_valid (half1_valid),
		.half0_data  (half0_data),
		.half1_data  (half1_data),
		.offset      (offset)
	);

	for (genvar i = 0; i < `NUM_CU; i++) begin : cu_read
		edge_data_read_control read_ctrl (
			.clock       (clock),
			.rstn        (rstn),
			.enable      (enable),
			.half0_valid (half0_valid[i]),
			.half1_valid (half1_valid[i]),
			.half0_data  (half0_data),
			.half1_data  (half1_data),
			.offset      (offset),
			.edge_request(edge_request[i]),
			.word_valid  (word_valid[i]),
			.word        (word[i])
		);
	end

	edge_data_collector collector (
		.clock       (clock),
		.rstn        (rstn),
		.enable      (enable),
		.word_valid  (word_valid),
		.word        (word),
		.edge_request(edge_request),
		.out_ready   (out_ready),
		.edge_valid  (edge_valid),
		.edge_cu     (edge_cu),
		.edge_data   (edge_data)
	);

endmodule

// ==== logic/edge_data_collector.sv ====
//////////////////////////////////////////////////////////////////////
// Edge data collector
// Polls the unit buffers in turn and queues tagged words for output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "graph_defines.svh"

module edge_data_collector import graph_pkg::*; (
	input  logic               clock,
	input  logic               rstn,
	input  logic               enable,
	input  logic [`NUM_CU-1:0] word_valid,
	input  edge_word_t         word [`NUM_CU],
	output logic [`NUM_CU-1:0] edge_request,
	input  logic               out_ready,
	output logic               edge_valid,
	output cu_id_t             edge_cu,
	output edge_word_t         edge_data
);

	localparam int OCC_W = $clog2(`SKID_DEPTH + 1);

	cu_id_t       rr_ptr;
	logic [OCC_W-1:0] occ;
	logic         issue;
	logic         ans_valid;
	cu_id_t       ans_idx;
	tagged_edge_t ans_item;
	tagged_edge_t head;
	logic         q_push;
	logic         q_pop;
	logic         q_full;
	logic         q_empty;

	//////////////////////////////////////////////////////////////////////
	// Request side
	//////////////////////////////////////////////////////////////////////

	// Room for this answer and the two still in flight
	assign issue = enable && (occ <= OCC_W'(`SKID_DEPTH - 3));

	always_comb begin
		for (int i = 0; i < `NUM_CU; i++) begin
			edge_request[i] = issue && (rr_ptr == cu_id_t'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rr_ptr <= '0;
		end else if (issue) begin
			rr_ptr <= (rr_ptr == cu_id_t'(`NUM_CU - 1)) ? '0 : rr_ptr + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Answer side
	//////////////////////////////////////////////////////////////////////

	// One-hot answer to unit index
	always_comb begin
		ans_idx = '0;
		for (int i = 0; i < `NUM_CU; i++) begin
			if (word_valid[i]) begin
				ans_idx = cu_id_t'(i);
			end
		end
	end

	assign ans_valid     = |word_valid;
	assign ans_item.cu   = ans_idx;
	assign ans_item.data = word[ans_idx];

	assign q_push = ans_valid;
	assign q_pop  = out_ready && !q_empty;

	// Fill level mirrors the queue
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			occ <= '0;
		end else begin
			case ({q_push, q_pop})
				2'b10:   occ <= occ + 1'b1;
				2'b01:   occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
		end
	end

	sync_fifo #(
		.item_t(tagged_edge_t),
		.DEPTH (`SKID_DEPTH)
	) skid_q (
		.clock    (clock),
		.rstn     (rstn),
		.push     (q_push),
		.push_data(ans_item),
		.full     (q_full),
		.pop      (q_pop),
		.pop_data (head),
		.pop_valid(edge_valid),
		.empty    (q_empty)
	);

	assign edge_cu   = head.cu;
	assign edge_data = head.data;

	// Units are polled one at a time, so answers never collide
	a_one_answer: assert property (@(posedge clock) disable iff (!rstn) $onehot0(word_valid))
		else $error("more than one unit answered in the same cycle");

endmodule

// ==== logic/edge_data_read_control.sv ====
//////////////////////////////////////////////////////////////////////
// Edge data read control
// Joins the two halves of a line, picks the edge word at the offset,
// reverses its bytes and keeps it in the unit's edge buffer
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "graph_defines.svh"

module edge_data_read_control import graph_pkg::*; (
	input  logic         clock,
	input  logic         rstn,
	input  logic         enable,
	input  logic         half0_valid,
	input  logic         half1_valid,
	input  half_line_t   half0_data,
	input  half_line_t   half1_data,
	input  word_offset_t offset,
	input  logic         edge_request,
	output logic         word_valid,
	output edge_word_t   word
);

	// Half 1 waits here for its half 0
	logic                  h1_valid_q;
	half_line_t            h1_data_q;

	// Pipeline stages
	logic                  line_valid;
	logic [`LINE_BITS-1:0] line_q;
	word_offset_t          line_off;
	logic                  sel_valid;
	edge_word_t            sel_word;
	logic                  swap_valid;
	edge_word_t            swap_word;

	// Buffer side
	logic                  req_q;
	logic                  buf_push;
	logic                  buf_pop;
	logic                  buf_full;
	logic                  buf_empty;

	//////////////////////////////////////////////////////////////////////
	// Align and join
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			h1_valid_q <= 1'b0;
			line_valid <= 1'b0;
			sel_valid  <= 1'b0;
			swap_valid <= 1'b0;
		end else begin
			h1_valid_q <= half1_valid;
			line_valid <= enable && half0_valid && h1_valid_q;
			sel_valid  <= line_valid;
			swap_valid <= sel_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (half1_valid) begin
			h1_data_q <= half1_data;
		end
		// Half 0 is the upper part of the line
		if (half0_valid && h1_valid_q) begin
			line_q   <= {half0_data, h1_data_q};
			line_off <= offset;
		end
		// Offset 0 picks the most significant word
		sel_word  <= line_q[`LINE_BITS - 1 - line_off * `WORD_BITS -: `WORD_BITS];
		swap_word <= {<<8{sel_word}};
	end

	//////////////////////////////////////////////////////////////////////
	// Edge buffer
	//////////////////////////////////////////////////////////////////////

	// Words beyond a full buffer are dropped
	assign buf_push = swap_valid && !buf_full;

	// Request answered two cycles later, ignored when nothing is stored
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			req_q <= 1'b0;
		end else begin
			req_q <= enable && edge_request && !buf_empty;
		end
	end

	assign buf_pop = req_q;

	sync_fifo #(
		.item_t(edge_word_t),
		.DEPTH (`EDGE_BUF_DEPTH)
	) edge_buf (
		.clock    (clock),
		.rstn     (rstn),
		.push     (buf_push),
		.push_data(swap_word),
		.full     (buf_full),
		.pop      (buf_pop),
		.pop_data (word),
		.pop_valid(word_valid),
		.empty    (buf_empty)
	);

	// A joined line must reach the buffer, so a full buffer here loses a word
	a_no_drop: assert property (
		@(posedge clock) disable iff (!rstn)
		line_valid |-> ##2 !buf_full
	) else $error("edge buffer full, word dropped");

endmodule

// ==== logic/read_response_router.sv ====
//////////////////////////////////////////////////////////////////////
// Read response router
// Registers both half-line channels and steers them by unit id
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "graph_defines.svh"

module read_response_router import graph_pkg::*; (
	input  logic                clock,
	input  logic                rstn,
	input  logic                enable,
	input  logic                resp0_valid,
	input  logic                resp1_valid,
	input  cu_id_t              resp0_cu,
	input  cu_id_t              resp1_cu,
	input  word_offset_t        resp0_offset,
	input  half_line_t          resp0_data,
	input  half_line_t          resp1_data,
	output logic [`NUM_CU-1:0]  half0_valid,
	output logic [`NUM_CU-1:0]  half1_valid,
	output half_line_t          half0_data,
	output half_line_t          half1_data,
	output word_offset_t        offset
);

	// One-hot unit strobes, nothing captured while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			half0_valid <= '0;
			half1_valid <= '0;
		end else begin
			for (int i = 0; i < `NUM_CU; i++) begin
				half0_valid[i] <= enable && resp0_valid && (resp0_cu == cu_id_t'(i));
				half1_valid[i] <= enable && resp1_valid && (resp1_cu == cu_id_t'(i));
			end
		end
	end

	// Payload goes to every unit
	always_ff @(posedge clock) begin
		if (enable && resp0_valid) begin
			half0_data <= resp0_data;
			offset     <= resp0_offset;
		end
		if (enable && resp1_valid) begin
			half1_data <= resp1_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Protocol check
	//////////////////////////////////////////////////////////////////////

	// Half 1 of a line leads half 0 by one cycle with the same id
	a_pair_order: assert property (
		@(posedge clock) disable iff (!rstn)
		(enable && resp0_valid) |-> ($past(resp1_valid) && resp0_cu == $past(resp1_cu))
	) else $error("half 0 without a matching half 1 one cycle earlier");

endmodule

// ==== logic/sync_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// Synchronous FIFO
// Circular buffer with a registered read port, generic payload type
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "graph_defines.svh"

module sync_fifo import graph_pkg::*; #(
	parameter type item_t = edge_word_t,
	parameter int  DEPTH  = `EDGE_BUF_DEPTH
) (
	input  logic  clock,
	input  logic  rstn,
	input  logic  push,
	input  item_t push_data,
	output logic  full,
	input  logic  pop,
	output item_t pop_data,
	output logic  pop_valid,
	output logic  empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	item_t             mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;

	assign full  = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);

	// Storage, no reset
	always_ff @(posedge clock) begin
		if (push && !full) begin
			mem[wr_ptr] <= push_data;
		end
		if (pop && !empty) begin
			pop_data <= mem[rd_ptr];
		end
	end

	// Pointers and fill level
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= pop && !empty;
			if (push && !full) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop && !empty) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push && !full, pop && !empty})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("push into a full FIFO");

	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("pop from an empty FIFO");

endmodule

// ==== logic/graph_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Edge read path types
// Ids, offsets and payloads shared across the read path
//////////////////////////////////////////////////////////////////////

`include "graph_defines.svh"

package graph_pkg;

	// Compute unit index
	typedef logic [$clog2(`NUM_CU)-1:0] cu_id_t;

	// Word position inside a cacheline, 0 is the most significant word
	typedef logic [$clog2(`LINE_BITS/`WORD_BITS)-1:0] word_offset_t;

	// One half-line response
	typedef logic [`HALF_BITS-1:0] half_line_t;

	// One edge word
	typedef logic [`WORD_BITS-1:0] edge_word_t;

	// Edge word with the unit it came from
	typedef struct packed {
		cu_id_t     cu;
		edge_word_t data;
	} tagged_edge_t;

endpackage

// ==== logic/graph_defines.svh ====
//////////////////////////////////////////////////////////////////////
// Edge read path sizes
// Compute unit count, line and word widths, buffer depths
//////////////////////////////////////////////////////////////////////

`ifndef GRAPH_DEFINES_SVH
`define GRAPH_DEFINES_SVH

// Compute units served by the memory port
`define NUM_CU 4

// One cacheline, returned as two halves
`define LINE_BITS 128
`define HALF_BITS 64

// One edge word inside a line
`define WORD_BITS 32

// Per-unit edge buffer
`define EDGE_BUF_DEPTH 8

// Collector output queue
`define SKID_DEPTH 4

`endif
